// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= axi_ram_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only if the simulation output holds the pass message
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/axi_ram_pkg.sv ====
// shared widths, types, codes and state encodings for the AXI4 RAM slave
// imported by every design module; next_beat_addr serves both burst engines
`default_nettype none

package axi_ram_pkg;

    localparam int AXI_ADDR_W = 16;                 // byte address
    localparam int AXI_DATA_W = 32;
    localparam int AXI_ID_W   = 4;
    localparam int BEAT_BYTES = AXI_DATA_W / 8;
    localparam int BEAT_LSB   = $clog2(BEAT_BYTES); // byte offset bits within a beat
    localparam int RAM_ADDR_W = AXI_ADDR_W - BEAT_LSB;

    typedef logic [AXI_ADDR_W-1:0]   axi_addr_t;
    typedef logic [AXI_DATA_W-1:0]   axi_data_t;
    typedef logic [BEAT_BYTES-1:0]   axi_strb_t;
    typedef logic [AXI_ID_W-1:0]     axi_id_t;
    typedef logic [7:0]              axi_len_t;   // beats minus one
    typedef logic [1:0]              axi_burst_t;
    typedef logic [1:0]              axi_resp_t;
    typedef logic [RAM_ADDR_W-1:0]   ram_addr_t;  // word address

    // burst type codes, 3 is reserved
    localparam axi_burst_t BURST_FIXED = 2'd0;
    localparam axi_burst_t BURST_INCR  = 2'd1;
    localparam axi_burst_t BURST_WRAP  = 2'd2;

    localparam axi_resp_t RESP_OKAY = 2'd0;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DATA,
        WR_RESP
    } wr_state_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_FETCH,
        RD_DATA
    } rd_state_t;

    // address of the beat after addr within a burst
    function automatic axi_addr_t next_beat_addr(input axi_addr_t  addr,
                                                 input axi_burst_t burst,
                                                 input axi_len_t   len);
        axi_addr_t aligned;
        axi_addr_t stepped;
        axi_addr_t wrap_mask;
        aligned   = addr & ~axi_addr_t'(BEAT_BYTES - 1);
        stepped   = aligned + axi_addr_t'(BEAT_BYTES);
        wrap_mask = ((axi_addr_t'(len) + 16'd1) << BEAT_LSB) - 16'd1; // block size minus one
        case (burst)
            BURST_FIXED: return addr;
            BURST_INCR:  return stepped;
            BURST_WRAP: begin
                // stepped onto the next block, go back to the start of this one
                if ((stepped & wrap_mask) == '0) begin
                    return aligned & ~wrap_mask;
                end
                return stepped;
            end
            default:     return stepped; // reserved code behaves as INCR
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== design/axi_ram_top.sv ====
// AXI4 slave RAM: write and read engines run side by side over one
// pseudo-dual-port memory; one burst in flight per direction
`timescale 1ns/1ps
`default_nettype none

module axi_ram_top (
    input  logic                    S_AXI_ACLK,
    input  logic                    S_AXI_ARESETN,

    // AW channel
    input  axi_ram_pkg::axi_id_t    S_AXI_AWID,
    input  axi_ram_pkg::axi_addr_t  S_AXI_AWADDR,
    input  axi_ram_pkg::axi_len_t   S_AXI_AWLEN,
    input  axi_ram_pkg::axi_burst_t S_AXI_AWBURST,
    input  logic                    S_AXI_AWVALID,
    output logic                    S_AXI_AWREADY,

    // W channel
    input  axi_ram_pkg::axi_data_t  S_AXI_WDATA,
    input  axi_ram_pkg::axi_strb_t  S_AXI_WSTRB,
    input  logic                    S_AXI_WLAST,
    input  logic                    S_AXI_WVALID,
    output logic                    S_AXI_WREADY,

    // B channel
    output axi_ram_pkg::axi_id_t    S_AXI_BID,
    output axi_ram_pkg::axi_resp_t  S_AXI_BRESP,
    output logic                    S_AXI_BVALID,
    input  logic                    S_AXI_BREADY,

    // AR channel
    input  axi_ram_pkg::axi_id_t    S_AXI_ARID,
    input  axi_ram_pkg::axi_addr_t  S_AXI_ARADDR,
    input  axi_ram_pkg::axi_len_t   S_AXI_ARLEN,
    input  axi_ram_pkg::axi_burst_t S_AXI_ARBURST,
    input  logic                    S_AXI_ARVALID,
    output logic                    S_AXI_ARREADY,

    // R channel
    output axi_ram_pkg::axi_id_t    S_AXI_RID,
    output axi_ram_pkg::axi_data_t  S_AXI_RDATA,
    output axi_ram_pkg::axi_resp_t  S_AXI_RRESP,
    output logic                    S_AXI_RLAST,
    output logic                    S_AXI_RVALID,
    input  logic                    S_AXI_RREADY
);

    import axi_ram_pkg::*;

    // write engine to RAM
    logic      ram_we;
    ram_addr_t ram_waddr;
    axi_data_t ram_wdata;
    axi_strb_t ram_wstrb;

    // read engine to RAM
    logic      ram_re;
    ram_addr_t ram_raddr;

    axi_write_engine u_wr (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .awid          (S_AXI_AWID),
        .awaddr        (S_AXI_AWADDR),
        .awlen         (S_AXI_AWLEN),
        .awburst       (S_AXI_AWBURST),
        .awvalid       (S_AXI_AWVALID),
        .awready       (S_AXI_AWREADY),
        .wdata         (S_AXI_WDATA),
        .wstrb         (S_AXI_WSTRB),
        .wlast         (S_AXI_WLAST),
        .wvalid        (S_AXI_WVALID),
        .wready        (S_AXI_WREADY),
        .bid           (S_AXI_BID),
        .bresp         (S_AXI_BRESP),
        .bvalid        (S_AXI_BVALID),
        .bready        (S_AXI_BREADY),
        .ram_we        (ram_we),
        .ram_waddr     (ram_waddr),
        .ram_wdata     (ram_wdata),
        .ram_wstrb     (ram_wstrb)
    );

    axi_read_engine u_rd (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .arid          (S_AXI_ARID),
        .araddr        (S_AXI_ARADDR),
        .arlen         (S_AXI_ARLEN),
        .arburst       (S_AXI_ARBURST),
        .arvalid       (S_AXI_ARVALID),
        .arready       (S_AXI_ARREADY),
        .rid           (S_AXI_RID),
        .rresp         (S_AXI_RRESP),
        .rlast         (S_AXI_RLAST),
        .rvalid        (S_AXI_RVALID),
        .rready        (S_AXI_RREADY),
        .ram_re        (ram_re),
        .ram_raddr     (ram_raddr)
    );

    // RDATA is the RAM output register itself
    ram_pseudo_dual u_ram (
        .S_AXI_ACLK (S_AXI_ACLK),
        .ram_we     (ram_we),
        .ram_waddr  (ram_waddr),
        .ram_wdata  (ram_wdata),
        .ram_wstrb  (ram_wstrb),
        .ram_re     (ram_re),
        .ram_raddr  (ram_raddr),
        .ram_rdata  (S_AXI_RDATA)
    );

endmodule

`default_nettype wire

// ==== design/axi_read_engine.sv ====
// AXI4 read side: one AR burst at a time, one RAM read per beat
// R data comes from the RAM output register, so RVALID follows each ram_re by a cycle
`timescale 1ns/1ps
`default_nettype none

module axi_read_engine (
    input  logic                    S_AXI_ACLK,
    input  logic                    S_AXI_ARESETN,

    // read address
    input  axi_ram_pkg::axi_id_t    arid,
    input  axi_ram_pkg::axi_addr_t  araddr,
    input  axi_ram_pkg::axi_len_t   arlen,
    input  axi_ram_pkg::axi_burst_t arburst,
    input  logic                    arvalid,
    output logic                    arready,

    // read data, RDATA itself comes from the RAM
    output axi_ram_pkg::axi_id_t    rid,
    output axi_ram_pkg::axi_resp_t  rresp,
    output logic                    rlast,
    output logic                    rvalid,
    input  logic                    rready,

    // RAM read port
    output logic                    ram_re,
    output axi_ram_pkg::ram_addr_t  ram_raddr
);

    import axi_ram_pkg::*;

    rd_state_t  state;
    axi_len_t   beat_cnt;  // beats already accepted in this burst
    axi_id_t    id_q;
    axi_addr_t  addr_q;
    axi_len_t   len_q;
    axi_burst_t burst_q;

    logic ar_fire;
    logic r_fire;
    logic last_beat;

    assign arready = (state == RD_IDLE);
    assign ram_re  = (state == RD_FETCH);  // single cycle, state always moves on
    assign rvalid  = (state == RD_DATA);

    assign last_beat = (beat_cnt == len_q);
    assign rlast     = rvalid && last_beat;
    assign rid       = id_q;
    assign rresp     = RESP_OKAY;

    assign ram_raddr = addr_q[AXI_ADDR_W-1:BEAT_LSB];

    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    // burst control and beat count
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state    <= RD_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (ar_fire) begin
                        state    <= RD_FETCH;
                        beat_cnt <= '0;
                    end
                end
                RD_FETCH: begin
                    state <= RD_DATA;
                end
                RD_DATA: begin
                    if (r_fire) begin
                        if (last_beat) begin
                            state <= RD_IDLE;
                        end else begin
                            state    <= RD_FETCH;  // one idle cycle between beats
                            beat_cnt <= beat_cnt + 8'd1;
                        end
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // burst payload
    always_ff @(posedge S_AXI_ACLK) begin
        if (ar_fire) begin
            id_q    <= arid;
            addr_q  <= araddr;
            len_q   <= arlen;
            burst_q <= arburst;
        end else if (r_fire && !last_beat) begin
            addr_q <= next_beat_addr(addr_q, burst_q, len_q);
        end
    end

endmodule

`default_nettype wire

// ==== design/axi_write_engine.sv ====
// AXI4 write side: takes one AW burst at a time, forwards W beats to the RAM
// write port and returns a single B response per burst
`timescale 1ns/1ps
`default_nettype none

module axi_write_engine (
    input  logic                    S_AXI_ACLK,
    input  logic                    S_AXI_ARESETN,

    // write address
    input  axi_ram_pkg::axi_id_t    awid,
    input  axi_ram_pkg::axi_addr_t  awaddr,
    input  axi_ram_pkg::axi_len_t   awlen,
    input  axi_ram_pkg::axi_burst_t awburst,
    input  logic                    awvalid,
    output logic                    awready,

    // write data
    input  axi_ram_pkg::axi_data_t  wdata,
    input  axi_ram_pkg::axi_strb_t  wstrb,
    input  logic                    wlast,
    input  logic                    wvalid,
    output logic                    wready,

    // write response
    output axi_ram_pkg::axi_id_t    bid,
    output axi_ram_pkg::axi_resp_t  bresp,
    output logic                    bvalid,
    input  logic                    bready,

    // RAM write port
    output logic                    ram_we,
    output axi_ram_pkg::ram_addr_t  ram_waddr,
    output axi_ram_pkg::axi_data_t  ram_wdata,
    output axi_ram_pkg::axi_strb_t  ram_wstrb
);

    import axi_ram_pkg::*;

    wr_state_t  state;
    axi_id_t    id_q;     // captured AWID, echoed on B
    axi_addr_t  addr_q;   // byte address of the current beat
    axi_len_t   len_q;
    axi_burst_t burst_q;

    logic aw_fire;
    logic w_fire;
    logic b_fire;

    assign awready = (state == WR_IDLE);
    assign wready  = (state == WR_DATA);
    assign bvalid  = (state == WR_RESP);
    assign bid     = id_q;
    assign bresp   = RESP_OKAY;

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign b_fire  = bvalid && bready;

    // each accepted beat goes straight to the RAM on the same edge
    assign ram_we    = w_fire;
    assign ram_waddr = addr_q[AXI_ADDR_W-1:BEAT_LSB];
    assign ram_wdata = wdata;
    assign ram_wstrb = wstrb;

    // burst control
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= WR_IDLE;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (aw_fire) begin
                        state <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (w_fire && wlast) begin // burst ends on WLAST, beats not counted
                        state <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (b_fire) begin
                        state <= WR_IDLE;
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    // burst payload
    always_ff @(posedge S_AXI_ACLK) begin
        if (aw_fire) begin
            id_q    <= awid;
            addr_q  <= awaddr;
            len_q   <= awlen;
            burst_q <= awburst;
        end else if (w_fire) begin
            addr_q <= next_beat_addr(addr_q, burst_q, len_q);
        end
    end

endmodule

`default_nettype wire

// ==== design/ram_pseudo_dual.sv ====
// word RAM with one byte-masked write port and one registered read port
// read data is loaded only on ram_re and held until the next read
`timescale 1ns/1ps
`default_nettype none

module ram_pseudo_dual (
    input  logic                   S_AXI_ACLK,

    // write port
    input  logic                   ram_we,
    input  axi_ram_pkg::ram_addr_t ram_waddr,
    input  axi_ram_pkg::axi_data_t ram_wdata,
    input  axi_ram_pkg::axi_strb_t ram_wstrb,

    // read port
    input  logic                   ram_re,
    input  axi_ram_pkg::ram_addr_t ram_raddr,
    output axi_ram_pkg::axi_data_t ram_rdata
);

    import axi_ram_pkg::*;

    axi_data_t mem [0:(2**RAM_ADDR_W)-1];

    // byte lanes written only where strobed
    always_ff @(posedge S_AXI_ACLK) begin
        if (ram_we) begin
            for (int lane = 0; lane < BEAT_BYTES; lane++) begin
                if (ram_wstrb[lane]) begin
                    mem[ram_waddr][lane*8 +: 8] <= ram_wdata[lane*8 +: 8];
                end
            end
        end
    end

    // same-edge write to the same word is not seen here, old data returned
    always_ff @(posedge S_AXI_ACLK) begin
        if (ram_re) begin
            ram_rdata <= mem[ram_raddr];
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
design/axi_ram_pkg.sv
design/ram_pseudo_dual.sv
design/axi_write_engine.sv
design/axi_read_engine.sv
design/axi_ram_top.sv
tests/axi_ram_tb.sv

// ==== tests/axi_ram_tb.sv ====
// testbench for axi_ram_top that runs a table of AXI bursts through the DUT
// and checks every B and R beat against a byte-level model of the memory
`timescale 1ns/1ps
`default_nettype none

module axi_ram_tb;

    import axi_ram_pkg::*;

    typedef struct packed {
        logic       is_write;
        axi_id_t    id;
        axi_addr_t  addr;
        axi_len_t   len;
        axi_burst_t burst;
        axi_strb_t  strb;
        logic       bp;      // random BREADY/RREADY stalls
    } txn_t;

    localparam int NUM_TXN = 12;
    localparam int TIMEOUT = 40;   // cycles allowed per wait

    // kind, ID, address, length, burst, strobes, back-pressure
    localparam txn_t TXNS [NUM_TXN] = '{
        {1'b1, 4'd3,  16'h0100, 8'd7, BURST_INCR,  4'hF, 1'b0},  // 8-beat INCR
        {1'b0, 4'd5,  16'h0100, 8'd7, BURST_INCR,  4'hF, 1'b0},
        {1'b1, 4'd1,  16'h0200, 8'd3, BURST_INCR,  4'hF, 1'b0},  // known data first
        {1'b1, 4'd2,  16'h0200, 8'd3, BURST_INCR,  4'h5, 1'b0},  // then partial strobes
        {1'b0, 4'd6,  16'h0200, 8'd3, BURST_INCR,  4'hF, 1'b0},
        {1'b1, 4'd7,  16'h0300, 8'd3, BURST_FIXED, 4'hF, 1'b0},
        {1'b0, 4'd8,  16'h0300, 8'd2, BURST_FIXED, 4'hF, 1'b0},
        {1'b1, 4'd9,  16'h0408, 8'd3, BURST_WRAP,  4'hF, 1'b0},  // fills 8, 12, 0, 4
        {1'b0, 4'd10, 16'h0400, 8'd3, BURST_INCR,  4'hF, 1'b0},
        {1'b1, 4'd11, 16'h0100, 8'd5, BURST_INCR,  4'hA, 1'b1},  // over the first burst
        {1'b0, 4'd12, 16'h0100, 8'd5, BURST_INCR,  4'hF, 1'b1},
        {1'b0, 4'd13, 16'h040C, 8'd3, BURST_WRAP,  4'hF, 1'b1}
    };

    logic       S_AXI_ACLK;
    logic       S_AXI_ARESETN;
    axi_id_t    S_AXI_AWID, S_AXI_ARID, S_AXI_BID, S_AXI_RID;
    axi_addr_t  S_AXI_AWADDR, S_AXI_ARADDR;
    axi_len_t   S_AXI_AWLEN, S_AXI_ARLEN;
    axi_burst_t S_AXI_AWBURST, S_AXI_ARBURST;
    axi_data_t  S_AXI_WDATA, S_AXI_RDATA;
    axi_strb_t  S_AXI_WSTRB;
    axi_resp_t  S_AXI_BRESP, S_AXI_RRESP;
    logic       S_AXI_AWVALID, S_AXI_AWREADY, S_AXI_WLAST, S_AXI_WVALID, S_AXI_WREADY;
    logic       S_AXI_BVALID, S_AXI_BREADY, S_AXI_ARVALID, S_AXI_ARREADY;
    logic       S_AXI_RLAST, S_AXI_RVALID, S_AXI_RREADY;

    logic [7:0] model_mem [0:65535];  // reference memory, one byte per entry
    integer     seed;

    axi_ram_top DUT (.*);

    initial begin
        S_AXI_ACLK = 1'b0;
        forever #2 S_AXI_ACLK = ~S_AXI_ACLK;
    end

    task automatic stop_with_failure();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_data(input string name, input axi_data_t got, input axi_data_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s expected %h got %h", $time, name, exp, got);
            stop_with_failure();
        end
    endtask

    task automatic check_id(input string name, input axi_id_t got, input axi_id_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s expected %h got %h", $time, name, exp, got);
            stop_with_failure();
        end
    endtask

    task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s expected %h got %h", $time, name, exp, got);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s expected %b got %b", $time, name, exp, got);
            stop_with_failure();
        end
    endtask

    // one falling edge of a bounded wait
    task automatic wait_cycle(inout int waited, input string what);
        @(negedge S_AXI_ACLK);
        waited++;
        if (waited > TIMEOUT) begin
            $display("timeout after %0d cycles: %s", TIMEOUT, what);
            stop_with_failure();
        end
    endtask

    // address of the next beat for FIXED, INCR and WRAP bursts
    function automatic axi_addr_t step_addr(input axi_addr_t addr, input axi_burst_t burst,
                                            input axi_len_t len);
        int next;
        int size;
        next = (int'(addr) & ~3) + 4;
        size = (int'(len) + 1) * 4;
        if (burst == BURST_FIXED) begin
            return addr;
        end
        if (burst == BURST_WRAP && (next % size) == 0) begin
            next = next - size;
        end
        return axi_addr_t'(next);
    endfunction

    function automatic axi_data_t model_word(input axi_addr_t addr);
        axi_data_t w;
        for (int b = 0; b < BEAT_BYTES; b++) begin
            w[b*8 +: 8] = model_mem[{addr[AXI_ADDR_W-1:BEAT_LSB], 2'(b)}];
        end
        return w;
    endfunction

    task automatic write_burst(input txn_t t);
        axi_addr_t addr;
        int        waited;
        int        hold;
        addr = t.addr;
        {S_AXI_AWID, S_AXI_AWADDR, S_AXI_AWLEN, S_AXI_AWBURST} = {t.id, t.addr, t.len, t.burst};
        S_AXI_AWVALID = 1'b1;
        waited = 0;
        while (!S_AXI_AWREADY) wait_cycle(waited, "AWREADY stayed low");
        @(negedge S_AXI_ACLK);
        S_AXI_AWVALID = 1'b0;
        for (int i = 0; i <= int'(t.len); i++) begin
            S_AXI_WDATA  = $random(seed);
            S_AXI_WSTRB  = t.strb;
            S_AXI_WLAST  = (i == int'(t.len));
            S_AXI_WVALID = 1'b1;
            waited = 0;
            while (!S_AXI_WREADY) wait_cycle(waited, "WREADY stayed low");
            for (int b = 0; b < BEAT_BYTES; b++) begin
                if (t.strb[b]) begin
                    model_mem[{addr[AXI_ADDR_W-1:BEAT_LSB], 2'(b)}] = S_AXI_WDATA[b*8 +: 8];
                end
            end
            addr = step_addr(addr, t.burst, t.len);
            @(negedge S_AXI_ACLK);
            S_AXI_WVALID = 1'b0;
            if (t.bp) repeat ($random(seed) & 1) @(negedge S_AXI_ACLK);  // W gaps
        end
        waited = 0;
        while (!S_AXI_BVALID) wait_cycle(waited, "BVALID never rose");
        hold = t.bp ? ($random(seed) & 3) + 1 : 0;
        for (int h = hold; h >= 0; h--) begin
            check_bit("BVALID", S_AXI_BVALID, 1'b1);
            check_id("BID", S_AXI_BID, t.id);
            check_resp("BRESP", S_AXI_BRESP, RESP_OKAY);
            check_bit("AWREADY", S_AXI_AWREADY, 1'b0);  // no new burst before B is taken
            S_AXI_BREADY = (h == 0);
            @(negedge S_AXI_ACLK);
        end
        S_AXI_BREADY = 1'b0;
        check_bit("AWREADY", S_AXI_AWREADY, 1'b1);
    endtask

    task automatic read_burst(input txn_t t);
        axi_addr_t addr;
        axi_data_t exp;
        int        waited;
        int        hold;
        addr = t.addr;
        {S_AXI_ARID, S_AXI_ARADDR, S_AXI_ARLEN, S_AXI_ARBURST} = {t.id, t.addr, t.len, t.burst};
        S_AXI_ARVALID = 1'b1;
        waited = 0;
        while (!S_AXI_ARREADY) wait_cycle(waited, "ARREADY stayed low");
        @(negedge S_AXI_ACLK);
        S_AXI_ARVALID = 1'b0;
        for (int i = 0; i <= int'(t.len); i++) begin
            exp    = model_word(addr);
            waited = 0;
            while (!S_AXI_RVALID) wait_cycle(waited, "RVALID never rose");
            hold = t.bp ? ($random(seed) & 3) + 1 : 0;
            for (int h = hold; h >= 0; h--) begin  // R beat must hold until taken
                check_bit("RVALID", S_AXI_RVALID, 1'b1);
                check_data("RDATA", S_AXI_RDATA, exp);
                check_id("RID", S_AXI_RID, t.id);
                check_resp("RRESP", S_AXI_RRESP, RESP_OKAY);
                check_bit("RLAST", S_AXI_RLAST, i == int'(t.len));
                check_bit("ARREADY", S_AXI_ARREADY, 1'b0);  // one read burst at a time
                S_AXI_RREADY = (h == 0);
                @(negedge S_AXI_ACLK);
            end
            S_AXI_RREADY = 1'b0;
            check_bit("RVALID", S_AXI_RVALID, 1'b0);  // gap while the next word is fetched
            addr = step_addr(addr, t.burst, t.len);
        end
        check_bit("ARREADY", S_AXI_ARREADY, 1'b1);
    endtask

    initial begin
        seed          = 18;
        S_AXI_ARESETN = 1'b0;
        {S_AXI_AWID, S_AXI_AWADDR, S_AXI_AWLEN, S_AXI_AWBURST, S_AXI_AWVALID} = '0;
        {S_AXI_WDATA, S_AXI_WSTRB, S_AXI_WLAST, S_AXI_WVALID, S_AXI_BREADY} = '0;
        {S_AXI_ARID, S_AXI_ARADDR, S_AXI_ARLEN, S_AXI_ARBURST, S_AXI_ARVALID} = '0;
        S_AXI_RREADY = 1'b0;
        repeat (2) @(negedge S_AXI_ACLK);
        S_AXI_ARESETN = 1'b1;
        @(negedge S_AXI_ACLK);
        check_bit("AWREADY", S_AXI_AWREADY, 1'b1);
        check_bit("ARREADY", S_AXI_ARREADY, 1'b1);
        check_bit("BVALID", S_AXI_BVALID, 1'b0);
        check_bit("RVALID", S_AXI_RVALID, 1'b0);
        check_bit("WREADY", S_AXI_WREADY, 1'b0);
        for (int n = 0; n < NUM_TXN; n++) begin
            if (TXNS[n].is_write) begin
                write_burst(TXNS[n]);
            end else begin
                read_burst(TXNS[n]);
            end
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire
